/* sources.f */
source/sdram_mux_pkg.sv
source/sdram_slot.sv
source/sdram_arbiter.sv
source/sdram_data_router.sv
source/sdram_mux.sv
dv/sdram_mem_model.sv
dv/sdram_mux_tb.sv

/* Bender.yml */
package:
  name: sdram_mux

sources:
  - source/sdram_mux_pkg.sv
  - source/sdram_slot.sv
  - source/sdram_arbiter.sv
  - source/sdram_data_router.sv
  - source/sdram_mux.sv
  - target: test
    files:
      - dv/sdram_mem_model.sv
      - dv/sdram_mux_tb.sv

/* dv/sdram_mux_tb.sv */
/*
 * Testbench for the SDRAM slot multiplexer.
 * Four clients run LFSR stimulus against the behavioral SDRAM model, and
 * every returned word is compared with a shadow copy of memory.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_mux_tb
    import sdram_mux_pkg::*;
();

    localparam int n_single  = 8;    // Reads per slot in the first test
    localparam int n_write   = 8;    // Write, then two read-backs each
    localparam int n_conc    = 16;   // Accesses per slot running together
    localparam int total_txn = num_slots * n_single + num_slots * 2 + n_write * 3
                               + num_slots * n_conc + 2;

    logic                               clk;
    logic                               rst_n;
    logic [num_slots-1:0]               slot_cs;
    logic [num_slots-1:0][slot_aw-1:0]  slot_addr;
    logic [num_slots-1:0]               slot_wr;
    logic [num_slots-1:0][dw-1:0]       slot_din;
    logic [num_slots-1:0][1:0]          slot_wrmask;
    logic [num_slots-1:0][dw-1:0]       slot_dout;
    logic [num_slots-1:0]               slot_ok;
    logic                               sdram_req;
    logic                               sdram_ack;
    logic [sdram_aw-1:0]                sdram_addr;
    logic                               sdram_rnw;
    logic [1:0]                         sdram_wrmask;
    logic [dw-1:0]                      data_write;
    logic                               data_rdy;
    logic [dw-1:0]                      data_read;

    logic [dw-1:0]                      shadow [logic [sdram_aw-1:0]];
    logic [15:0]                        lfsr = 16'd10535;
    int                                 errors;
    int                                 tests_passed;
    int                                 tests_failed;
    logic [num_slots-1:0]               pend_on;     // Client waiting for ok
    logic [num_slots-1:0][sdram_aw-1:0] pend_addr;   // Its expected SDRAM address
    logic [slot_aw-1:0]                 conc_addr [num_slots][n_conc];
    logic                               conc_wr   [num_slots][n_conc];
    logic [dw-1:0]                      conc_din  [num_slots][n_conc];

    sdram_mux i_sdram_mux (.*);

    sdram_mem_model u_mem_model (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sdram_req    ( sdram_req    ),
        .sdram_ack    ( sdram_ack    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rnw    ( sdram_rnw    ),
        .sdram_wrmask ( sdram_wrmask ),
        .data_write   ( data_write   ),
        .data_rdy     ( data_rdy     ),
        .data_read    ( data_read    )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (200 * total_txn) @(posedge clk);
        $display("watchdog expired after %0d cycles, a client never saw ok", 200 * total_txn);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [dw-1:0] shadow_word(input logic [sdram_aw-1:0] a);
        if (shadow.exists(a))
            return shadow[a];
        return a[dw-1:0];   // Never written
    endfunction

    task automatic shadow_write(input logic [sdram_aw-1:0] a, input logic [1:0] mask,
                                input logic [dw-1:0] data);
        logic [dw-1:0] w;
        w = shadow_word(a);
        if (!mask[0])
            w[7:0] = data[7:0];
        if (!mask[1])
            w[15:8] = data[15:8];
        shadow[a] = w;
    endtask

    function automatic bit addr_wanted(input logic [sdram_aw-1:0] a);
        for (int s = 0; s < num_slots; s++)
            if (pend_on[s] && pend_addr[s] == a)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic report_error(input string test, input string what,
                                input logic [31:0] want, input logic [31:0] got);
        $display("error %s %s: expected %0h actual %0h", test, what, want, got);
        errors++;
    endtask

    task automatic end_test(input string test, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: pass", test);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test, errors - err_before);
        end
    endtask

    // One client access, returns data at ok, cycles waited and the SDRAM
    // commands accepted until its own one, that one included
    task automatic access(input int s, input logic [slot_aw-1:0] addr, input logic wr,
                          input logic [dw-1:0] din, input logic [1:0] mask,
                          output logic [dw-1:0] dout, output int waits, output int acks);
        logic own_acked;
        @(posedge clk);
        slot_cs[s]     <= 1'b1;
        slot_addr[s]   <= addr;
        slot_wr[s]     <= wr;
        slot_din[s]    <= din;
        slot_wrmask[s] <= mask;
        pend_addr[s] = slot_offset[s] + sdram_aw'(addr);
        pend_on[s]   = 1'b1;
        waits        = 0;
        acks         = 0;
        own_acked    = 1'b0;
        do begin
            @(posedge clk);
            waits++;
            if (!own_acked && sdram_req && sdram_ack) begin
                acks++;
                own_acked = sdram_addr == pend_addr[s];
            end
        end while (!slot_ok[s]);
        dout       = slot_dout[s];
        pend_on[s] = 1'b0;
        slot_cs[s] <= 1'b0;
    endtask

    // A stray request from a hit shows on sdram_req within a few cycles
    task automatic expect_no_sdram_req(input string test);
        bit seen;
        seen = 1'b0;
        repeat (4) begin
            @(posedge clk);
            if (sdram_req !== 1'b0)
                seen = 1'b1;
        end
        if (seen) begin
            $display("%s: sdram_req rose for a read served from the last word", test);
            errors++;
        end
    endtask

    task automatic client_run(input int s);
        logic [dw-1:0]       dout;
        logic [dw-1:0]       want;
        logic [sdram_aw-1:0] full;
        int                  waits;
        int                  acks;
        for (int i = 0; i < n_conc; i++) begin
            full = slot_offset[s] + sdram_aw'(conc_addr[s][i]);
            want = shadow_word(full);
            access(s, conc_addr[s][i], conc_wr[s][i], conc_din[s][i], 2'b00,
                   dout, waits, acks);
            if (conc_wr[s][i])
                shadow_write(full, 2'b00, conc_din[s][i]);
            else if (dout !== want)
                report_error("concurrency", $sformatf("slot %0d data", s), want, dout);
            if (acks > num_slots) begin   // Own grant plus one per other slot
                $display("slot %0d waited through %0d grants for one access", s, acks);
                errors++;
            end
        end
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            if (sdram_req !== 1'b0 || slot_ok !== '0) begin
                $display("sdram_req or slot_ok high while reset is asserted");
                errors++;
            end
        end
        rst_n <= 1'b1;
        @(posedge clk);
        if (sdram_req !== 1'b0 || slot_ok !== '0) begin
            $display("sdram_req or slot_ok high right after reset");
            errors++;
        end
    endtask

    // Accepted SDRAM commands, each must belong to a waiting client
    always @(posedge clk) begin
        if (rst_n && sdram_req && sdram_ack) begin
            if (!addr_wanted(sdram_addr)) begin
                $display("sdram_addr %0h lies outside every waiting slot's region", sdram_addr);
                errors++;
            end
        end
    end

    initial begin
        logic [slot_aw-1:0]  addr;
        logic [sdram_aw-1:0] full;
        logic [dw-1:0]       dout;
        logic [dw-1:0]       din;
        logic [1:0]          mask;
        int                  waits;
        int                  acks;
        int                  err0;

        rst_n       = 1'b0;
        slot_cs     = '0;
        slot_addr   = '0;
        slot_wr     = '0;
        slot_din    = '0;
        slot_wrmask = '0;
        pend_on     = '0;
        pend_addr   = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        err0 = errors;   // Offset mapping, one slot at a time
        for (int s = 0; s < num_slots; s++) begin
            for (int i = 0; i < n_single; i++) begin
                addr = slot_aw'(rand_bits(slot_aw));
                full = slot_offset[s] + sdram_aw'(addr);
                access(s, addr, 1'b0, '0, 2'b00, dout, waits, acks);
                if (dout !== shadow_word(full))
                    report_error("single_read", $sformatf("slot %0d", s), shadow_word(full), dout);
            end
        end
        end_test("single_read", err0);

        err0 = errors;
        for (int s = 0; s < num_slots; s++) begin
            addr = slot_aw'(rand_bits(slot_aw));
            full = slot_offset[s] + sdram_aw'(addr);
            access(s, addr, 1'b0, '0, 2'b00, dout, waits, acks);
            access(s, addr, 1'b0, '0, 2'b00, dout, waits, acks);
            if (dout !== shadow_word(full))
                report_error("hit_path", "data", shadow_word(full), dout);
            if (waits != 2)   // cs seen on one edge, ok on the next
                report_error("hit_path", "latency", 2, waits);
            expect_no_sdram_req("hit_path");
        end
        end_test("hit_path", err0);

        err0 = errors;   // Work RAM words above 0x8000 are also tile VRAM words
        for (int i = 0; i < n_write; i++) begin
            addr = slot_aw'(32'h8000 + rand_bits(17));
            din  = dw'(rand_bits(dw));
            mask = 2'(rand_bits(2));
            full = slot_offset[1] + sdram_aw'(addr);
            access(1, addr, 1'b1, din, mask, dout, waits, acks);
            shadow_write(full, mask, din);
            access(1, addr, 1'b0, '0, 2'b00, dout, waits, acks);
            if (dout !== shadow_word(full))
                report_error("write_back", "work ram port", shadow_word(full), dout);
            addr = slot_aw'(full - slot_offset[2]);
            access(2, addr, 1'b0, '0, 2'b00, dout, waits, acks);
            if (dout !== shadow_word(full))
                report_error("write_back", "tile vram port", shadow_word(full), dout);
        end
        end_test("write_back", err0);

        err0 = errors;
        for (int s = 0; s < num_slots; s++) begin
            for (int i = 0; i < n_conc; i++) begin
                conc_wr[s][i] = 1'b0;
                if (s == 1) begin
                    // Below 0x8000 so no VRAM reader sees these writes
                    conc_addr[s][i] = slot_aw'(rand_bits(15));
                    conc_wr[s][i]   = rand_bits(1) != 0;
                end else begin
                    conc_addr[s][i] = slot_aw'(rand_bits(slot_aw));
                end
                conc_din[s][i] = dw'(rand_bits(dw));
            end
        end
        fork
            client_run(0);
            client_run(1);
            client_run(2);
            client_run(3);
        join
        end_test("concurrency", err0);

        err0 = errors;
        addr = slot_aw'(rand_bits(slot_aw));
        full = slot_offset[0] + sdram_aw'(addr);
        access(0, addr, 1'b0, '0, 2'b00, dout, waits, acks);
        pulse_reset();
        access(0, addr, 1'b0, '0, 2'b00, dout, waits, acks);
        if (dout !== shadow_word(full))
            report_error("reset", "data", shadow_word(full), dout);
        if (acks == 0) begin
            $display("read after reset was answered without a new SDRAM access");
            errors++;
        end
        end_test("reset", err0);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/sdram_mem_model.sv */
/*
 * Behavioral SDRAM controller for the mux testbench.
 * Acks a held request after 0 to 3 cycles and returns data_rdy in ack order,
 * 2 to 5 cycles after each ack. Unwritten words read as their address bits.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_mem_model import sdram_mux_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sdram_req,
    output logic                sdram_ack,
    input  logic [sdram_aw-1:0] sdram_addr,
    input  logic                sdram_rnw,
    input  logic [1:0]          sdram_wrmask,   // Active low per byte
    input  logic [dw-1:0]       data_write,
    output logic                data_rdy,
    output logic [dw-1:0]       data_read
);

    logic [dw-1:0] mem [logic [sdram_aw-1:0]];   // Written words only
    logic [15:0]   lfsr = 16'd10535;
    int unsigned   cycle;
    int unsigned   due;
    int unsigned   last_due;
    int unsigned   ack_wait;
    int unsigned   due_q[$];        // Cycle at which each reply goes out
    logic [dw-1:0] word_q[$];

    function automatic logic [1:0] next_two_bits();
        logic [1:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < 2; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[0], fb};
        end
        return r;
    endfunction

    function automatic logic [dw-1:0] read_word(input logic [sdram_aw-1:0] a);
        if (mem.exists(a))
            return mem[a];
        return a[dw-1:0];
    endfunction

    task automatic store_word(input logic [sdram_aw-1:0] a, input logic [1:0] mask,
                              input logic [dw-1:0] data);
        logic [dw-1:0] w;
        w = read_word(a);
        if (!mask[0])
            w[7:0] = data[7:0];
        if (!mask[1])
            w[15:8] = data[15:8];
        mem[a] = w;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            cycle     = 0;
            last_due  = 0;
            ack_wait  = 0;
            due_q.delete();
            word_q.delete();
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (sdram_req && !sdram_ack) begin
                if (ack_wait == 0) begin
                    sdram_ack <= 1'b1;
                    if (!sdram_rnw)
                        store_word(sdram_addr, sdram_wrmask, data_write);
                    due = cycle + 2 + next_two_bits();
                    if (due <= last_due)
                        due = last_due + 1;   // Replies never overtake
                    last_due = due;
                    due_q.push_back(due);
                    word_q.push_back(read_word(sdram_addr));
                    ack_wait = next_two_bits();   // Delay for the next request
                end else begin
                    ack_wait--;
                end
            end
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                data_rdy  <= 1'b1;
                data_read <= word_q.pop_front();
            end
            cycle++;
        end
    end

endmodule

`default_nettype wire

/* source/sdram_mux.sv */
/*
 * Top level of the SDRAM slot multiplexer.
 * Four client slots share one SDRAM controller port through a round-robin
 * arbiter; the data router returns each reply to its slot.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_mux import sdram_mux_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // Clients, slot i at index i
    input  logic [num_slots-1:0]                slot_cs,
    input  logic [num_slots-1:0][slot_aw-1:0]   slot_addr,
    input  logic [num_slots-1:0]                slot_wr,
    input  logic [num_slots-1:0][dw-1:0]        slot_din,
    input  logic [num_slots-1:0][1:0]           slot_wrmask,   // Active low per byte
    output logic [num_slots-1:0][dw-1:0]        slot_dout,
    output logic [num_slots-1:0]                slot_ok,
    // SDRAM controller
    output logic                                sdram_req,
    input  logic                                sdram_ack,
    output logic [sdram_aw-1:0]                 sdram_addr,
    output logic                                sdram_rnw,
    output logic [1:0]                          sdram_wrmask,
    output logic [dw-1:0]                       data_write,
    input  logic                                data_rdy,
    input  logic [dw-1:0]                       data_read
);

    logic [num_slots-1:0]               req;
    logic [num_slots-1:0][sdram_aw-1:0] req_addr;
    logic [num_slots-1:0]               req_wr;
    logic [num_slots-1:0][dw-1:0]       req_din;
    logic [num_slots-1:0][1:0]          req_mask;
    logic [num_slots-1:0]               grant;
    logic [num_slots-1:0]               reply_valid;
    logic [dw-1:0]                      reply_data;
    logic                               reply_done;
    logic                               push_valid;
    logic [id_w-1:0]                    push_id;

    for (genvar g = 0; g < num_slots; g++) begin : g_slot
        sdram_slot #(.idx(g)) u_slot (
            .clk         ( clk            ),
            .rst_n       ( rst_n          ),
            .slot_cs     ( slot_cs[g]     ),
            .slot_addr   ( slot_addr[g]   ),
            .slot_wr     ( slot_wr[g]     ),
            .slot_din    ( slot_din[g]    ),
            .slot_wrmask ( slot_wrmask[g] ),
            .slot_ok     ( slot_ok[g]     ),
            .slot_dout   ( slot_dout[g]   ),
            .req         ( req[g]         ),
            .req_addr    ( req_addr[g]    ),
            .req_wr      ( req_wr[g]      ),
            .req_din     ( req_din[g]     ),
            .req_mask    ( req_mask[g]    ),
            .grant       ( grant[g]       ),
            .reply_valid ( reply_valid[g] ),
            .reply_data  ( reply_data     )   // Shared, qualified per slot
        );
    end

    sdram_arbiter u_arbiter (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .req          ( req          ),
        .req_addr     ( req_addr     ),
        .req_wr       ( req_wr       ),
        .req_din      ( req_din      ),
        .req_mask     ( req_mask     ),
        .grant        ( grant        ),
        .sdram_req    ( sdram_req    ),
        .sdram_ack    ( sdram_ack    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rnw    ( sdram_rnw    ),
        .sdram_wrmask ( sdram_wrmask ),
        .data_write   ( data_write   ),
        .push_valid   ( push_valid   ),
        .push_id      ( push_id      ),
        .reply_done   ( reply_done   )
    );

    sdram_data_router u_router (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .push_valid  ( push_valid  ),
        .push_id     ( push_id     ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .reply_valid ( reply_valid ),
        .reply_data  ( reply_data  ),
        .reply_done  ( reply_done  )
    );

endmodule

`default_nettype wire

/* source/sdram_data_router.sv */
/*
 * Steers each word from the SDRAM controller back to the slot that issued
 * the access. Owner ids are queued at ack time; the controller answers in
 * ack order, so the queue head always owns the next data_rdy.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_data_router import sdram_mux_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push_valid,
    input  logic [id_w-1:0]      push_id,
    input  logic                 data_rdy,
    input  logic [dw-1:0]        data_read,
    output logic [num_slots-1:0] reply_valid,
    output logic [dw-1:0]        reply_data,
    output logic                 reply_done
);

    logic [1:0][id_w-1:0] owner_q;   // Two-deep, matches the in-flight limit
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;
    logic [id_w-1:0]      head;

    assign head = owner_q[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            count       <= '0;
            reply_valid <= '0;
            reply_done  <= 1'b0;
        end else begin
            reply_valid <= '0;
            reply_done  <= data_rdy;   // Lets the arbiter free an in-flight slot
            count       <= count + 2'(push_valid) - 2'(data_rdy);
            if (push_valid)
                wr_ptr <= ~wr_ptr;
            if (data_rdy) begin
                rd_ptr            <= ~rd_ptr;
                reply_valid[head] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid)
            owner_q[wr_ptr] <= push_id;
        if (data_rdy)
            reply_data <= data_read;   // Meaningless for writes
    end

    // Controller must not answer more accesses than the arbiter issued
    a_rdy_has_owner: assert property (
        @(posedge clk) disable iff (!rst_n) data_rdy |-> count != 2'd0
    ) else $error("data_rdy with no access in flight");

endmodule

`default_nettype wire

/* source/sdram_arbiter.sv */
/*
 * Round-robin arbiter in front of the SDRAM controller port.
 * Grants one slot at a time, holds its command on the SDRAM side until
 * sdram_ack, and hands the owner id to the data router. At most two
 * accesses are allowed in flight at the controller.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter import sdram_mux_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // Slot requests
    input  logic [num_slots-1:0]                req,
    input  logic [num_slots-1:0][sdram_aw-1:0]  req_addr,
    input  logic [num_slots-1:0]                req_wr,
    input  logic [num_slots-1:0][dw-1:0]        req_din,
    input  logic [num_slots-1:0][1:0]           req_mask,
    output logic [num_slots-1:0]                grant,
    // SDRAM controller
    output logic                                sdram_req,
    input  logic                                sdram_ack,
    output logic [sdram_aw-1:0]                 sdram_addr,
    output logic                                sdram_rnw,
    output logic [1:0]                          sdram_wrmask,
    output logic [dw-1:0]                       data_write,
    // Router
    output logic                                push_valid,
    output logic [id_w-1:0]                     push_id,
    input  logic                                reply_done
);

    arb_state_e      state;
    logic [id_w-1:0] sel;           // Current owner, also the round-robin pointer
    logic [id_w-1:0] pick_id;
    logic [id_w-1:0] cand;
    logic            pick_valid;
    logic [1:0]      inflight;
    logic            acked;

    assign acked      = (state == wait_ack) && sdram_ack;
    assign push_valid = acked;
    assign push_id    = sel;

    // First requester after the last slot served
    always_comb begin
        pick_valid = 1'b0;
        pick_id    = sel;
        cand       = sel;
        for (int i = 1; i <= num_slots; i++) begin
            cand = id_w'(sel + i);  // Wraps since num_slots is a power of two
            if (!pick_valid && req[cand]) begin
                pick_valid = 1'b1;
                pick_id    = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            sel       <= id_w'(num_slots - 1);   // Slot 0 wins first
            grant     <= '0;
            sdram_req <= 1'b0;
            inflight  <= '0;
        end else begin
            grant    <= '0;
            inflight <= inflight + 2'(acked) - 2'(reply_done);
            case (state)
                idle: begin
                    if (pick_valid && inflight < 2'd2) begin
                        sel   <= pick_id;
                        state <= request;
                    end
                end
                request: begin
                    grant[sel] <= 1'b1;   // One-cycle pulse
                    sdram_req  <= 1'b1;
                    state      <= wait_ack;
                end
                wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Command registers follow the owner, held through back-pressure
    always_ff @(posedge clk) begin
        if (state == request) begin
            sdram_addr   <= req_addr[sel];
            sdram_rnw    <= ~req_wr[sel];
            sdram_wrmask <= req_mask[sel];
            data_write   <= req_din[sel];
        end
    end

    a_grant_requester: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant != '0 |-> $onehot(grant) && (grant & req) == grant && sdram_req
    ) else $error("grant %b not matched to a single requesting slot", grant);

    a_inflight_max: assert property (
        @(posedge clk) disable iff (!rst_n) inflight <= 2'd2
    ) else $error("more than two SDRAM accesses in flight");

endmodule

`default_nettype wire

/* source/sdram_slot.sv */
/*
 * One client port of the SDRAM mux.
 * Adds the slot's region offset, answers repeated reads from the last word
 * it fetched, and otherwise raises a request to the arbiter and waits for
 * the routed reply. Instantiated once per slot by the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_slot import sdram_mux_pkg::*; #(
    parameter int idx = 0   // Selects the region offset
) (
    input  logic                clk,
    input  logic                rst_n,
    // Client side
    input  logic                slot_cs,
    input  logic [slot_aw-1:0]  slot_addr,
    input  logic                slot_wr,
    input  logic [dw-1:0]       slot_din,
    input  logic [1:0]          slot_wrmask,
    output logic                slot_ok,
    output logic [dw-1:0]       slot_dout,
    // Arbiter side
    output logic                req,
    output logic [sdram_aw-1:0] req_addr,
    output logic                req_wr,
    output logic [dw-1:0]       req_din,
    output logic [1:0]          req_mask,
    input  logic                grant,
    // Router side
    input  logic                reply_valid,
    input  logic [dw-1:0]       reply_data
);

    logic               valid;        // last_data may serve hits
    logic [slot_aw-1:0] last_addr;
    logic [dw-1:0]      last_data;
    logic [slot_aw-1:0] pend_addr;    // Address of the access in progress
    logic               wait_reply;   // Granted, reply not yet back
    logic               ok_r;
    logic               same_addr;
    logic               done;
    logic               hit;
    logic               start;
    logic               issue;

    assign same_addr = slot_addr == last_addr;
    assign done      = ok_r & same_addr;   // Current access already answered
    assign hit       = slot_cs & ~slot_wr & valid & same_addr;
    assign start     = slot_cs & ~done & ~req & ~wait_reply;
    assign issue     = start & ~hit;

    // Drops at once when the client moves on to another address
    assign slot_ok   = ok_r & slot_cs & same_addr;
    assign slot_dout = last_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req        <= 1'b0;
            wait_reply <= 1'b0;
            ok_r       <= 1'b0;
            valid      <= 1'b0;
        end else begin
            if (grant) begin
                req        <= 1'b0;
                wait_reply <= 1'b1;
            end
            if (reply_valid) begin
                wait_reply <= 1'b0;
                ok_r       <= 1'b1;
                // A byte-masked write leaves the stored word incomplete
                valid      <= ~req_wr | (req_mask == 2'b00);
            end else if (!slot_cs || !same_addr) begin
                ok_r <= 1'b0;
            end
            if (start) begin
                if (hit)
                    ok_r <= 1'b1;   // Served from last_data
                else
                    req  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr  <= slot_offset[idx] + sdram_aw'(slot_addr);
            req_wr    <= slot_wr;
            req_din   <= slot_din;
            req_mask  <= slot_wrmask;
            pend_addr <= slot_addr;
        end
        if (reply_valid) begin
            last_addr <= pend_addr;
            last_data <= req_wr ? req_din : reply_data;
        end
    end

    // The router only returns data for an access this slot was granted
    a_reply_owned: assert property (
        @(posedge clk) disable iff (!rst_n) reply_valid |-> wait_reply
    ) else $error("slot %0d got a reply with no request outstanding", idx);

endmodule

`default_nettype wire

/* source/sdram_mux_pkg.sv */
/*
 * Shared constants and types for the SDRAM slot multiplexer.
 * Imported by the slot, arbiter, router and top level, and by the testbench
 * so that its model uses the same address map.
 */
`default_nettype none

package sdram_mux_pkg;

    localparam int num_slots = 4;   // ROM, work RAM, tile VRAM, palette VRAM
    localparam int slot_aw   = 18;  // Client word address
    localparam int sdram_aw  = 22;  // SDRAM word address
    localparam int dw        = 16;
    localparam int id_w      = 2;   // Wide enough for a slot index

    // Region base per slot, slot 3 first in the concatenation
    // Both VRAM readers look into the same region
    localparam logic [num_slots-1:0][sdram_aw-1:0] slot_offset = {
        22'h3B_0000,    // Palette VRAM
        22'h3B_0000,    // Tile VRAM
        22'h3A_8000,    // Work RAM
        22'h00_0000     // CPU ROM
    };

    typedef enum logic [1:0] {
        idle,       // Looking for a requesting slot
        request,    // Winner chosen, grant and command go out next edge
        wait_ack    // sdram_req held until the controller acks
    } arb_state_e;

endpackage

`default_nettype wire
